/* bank_ctrl.f */
bank_ctrl_pkg.sv
timing_cfg_if.sv
bank_timer_if.sv
bank_timing_regs.sv
bank_timers.sv
bank_fsm.sv
bank_ctrl_top.sv
bank_ctrl_assert.sv
tb_bank_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_bank_ctrl
FILELIST  ?= bank_ctrl.f
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) && echo "simulation passed" || (echo "simulation failed"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb_bank_ctrl.sv */
`timescale 1ns/1ps

module tb_bank_ctrl;
    import bank_ctrl_pkg::*;

    localparam int ACT     = 0;                     // bit index into cmd_req / gnt
    localparam int RD      = 1;
    localparam int WR      = 2;
    localparam int PRE     = 3;
    localparam int REF     = 4;
    localparam int TIMEOUT = 400;                   // cycles allowed per wait loop

    // short timings for the access tests
    localparam timing_t P_RC       = 8'd12;
    localparam timing_t P_RAS      = 8'd6;
    localparam timing_t P_RCD      = 8'd3;
    localparam timing_t P_RP       = 8'd2;
    localparam timing_t P_RTP      = 8'd2;
    localparam timing_t P_WTP      = 8'd4;
    localparam timing_t P_BURST    = 8'd2;
    localparam timing_t P_RFC      = 8'd7;
    localparam timing_t P_ROW_OPEN = 8'd10;

    localparam dram_ra_t ROW_A = 14'h0123;
    localparam dram_ra_t ROW_B = 14'h2a5c;
    localparam dram_ra_t ROW_C = 14'h1f00;
    localparam dram_ra_t ROW_D = 14'h3ffe;
    localparam dram_ca_t COL_A = 10'h011;
    localparam dram_ca_t COL_B = 10'h2c4;

    logic      clk;
    logic      rst_n;
    apb_addr_t paddr_i;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    apb_data_t pwdata_i;
    apb_data_t prdata_o;
    logic      pready_o;
    logic      pslverr_o;
    logic      req_valid_i;
    logic      req_wr_i;
    dram_ra_t  req_ra_i;
    dram_ca_t  req_ca_i;
    logic      req_ready_o;
    logic      act_req_o, rd_req_o, wr_req_o, pre_req_o, ref_req_o;
    dram_ra_t  ra_o;
    dram_ca_t  ca_o;
    logic      ref_req_i;
    logic      ref_gnt_o;
    logic [4:0] gnt;                                // one grant line per command

    wire act_gnt_i = gnt[ACT];
    wire rd_gnt_i  = gnt[RD];
    wire wr_gnt_i  = gnt[WR];
    wire pre_gnt_i = gnt[PRE];
    wire ref_gnt_i = gnt[REF];
    wire [4:0] cmd_req = {ref_req_o, pre_req_o, wr_req_o, rd_req_o, act_req_o};

    int          cyc = 0;                           // cycle count, read at negedge
    int          act_g;                             // cycle of last act grant
    int          acc_g;                             // cycle of last rd/wr grant
    int          wr_g;                              // cycle of last wr grant
    int          pre_g;
    int          ref_g;
    logic [15:0] lfsr_state = 16'd57908;

    bank_ctrl_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // galois lfsr, one step per delay bit
    function automatic logic [1:0] rand_delay();
        logic [1:0] d;
        d = 2'b00;
        for (int i = 0; i < 2; i++) begin
            lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
            d[i] = lfsr_state[0];
        end
        return d;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input apb_data_t got, input apb_data_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_ra(input dram_ra_t got, input dram_ra_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_ca(input dram_ca_t got, input dram_ca_t exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAIL %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_run($sformatf("FAIL %0t: %s got %b expected %b", $time, what, got, exp));
    endtask

    // cycles strictly between grant and request must cover the timing value
    task automatic check_gap(input int gap, input timing_t min_v, input string what);
        if (gap < int'(min_v))
            stop_run($sformatf("FAIL %0t: %s gap %0d below %0d", $time, what, gap, min_v));
    endtask

    task automatic apb_xfer(input apb_addr_t a, input logic wr, input apb_data_t wd,
                            output apb_data_t rd, output logic err);
        int n;
        @(posedge clk);
        paddr_i   <= a;                             // setup phase
        pwrite_i  <= wr;
        pwdata_i  <= wd;
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        @(posedge clk);
        penable_i <= 1'b1;                          // access phase
        n = 0;
        @(negedge clk);
        while (!pready_o) begin
            n++;
            if (n > TIMEOUT)
                stop_run("APB slave never raised pready_o");
            @(negedge clk);
        end
        rd = prdata_o;
        err = pslverr_o;
        @(posedge clk);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t a, input apb_data_t d, output logic err);
        apb_data_t unused;
        apb_xfer(a, 1'b1, d, unused, err);
    endtask

    task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
        apb_xfer(a, 1'b0, '0, d, err);
    endtask

    // returns at the negedge where the command request is first seen
    task automatic wait_cmd(input int w, input string what, output int r);
        int n;
        n = 0;
        @(negedge clk);
        while (!cmd_req[w]) begin
            if (cmd_req != 5'b0)
                stop_run($sformatf("FAIL %0t: request %b while waiting for %s",
                                   $time, cmd_req, what));
            n++;
            if (n > TIMEOUT)
                stop_run($sformatf("no %s request arrived in time", what));
            @(negedge clk);
        end
        r = cyc;
    endtask

    task automatic hold_cmd(input int w, input int n);
        dram_ra_t ra0;
        dram_ca_t ca0;
        ra0 = ra_o;
        ca0 = ca_o;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            check_flag(cmd_req[w], 1'b1, "request held without grant");
            check_flag(req_ready_o, 1'b0, "req_ready_o without grant");
            check_flag(ref_gnt_o, 1'b0, "ref_gnt_o without grant");
            check_ra(ra_o, ra0, "ra_o stable while waiting");
            check_ca(ca_o, ca0, "ca_o stable while waiting");
        end
    endtask

    // grant after 0..3 cycles, returns at the edge that drops the grant
    task automatic grant_cmd(input int w, output int g);
        hold_cmd(w, int'(rand_delay()));
        @(posedge clk);
        gnt <= 5'b00001 << w;
        @(negedge clk);
        g = cyc;
        check_flag(cmd_req[w], 1'b1, "request present with its grant");
        check_flag(req_ready_o, (w == RD || w == WR), "req_ready_o on grant cycle");
        check_flag(ref_gnt_o, (w == REF), "ref_gnt_o on grant cycle");
        @(posedge clk);
        gnt <= 5'b00000;
    endtask

    task automatic test_regs();
        apb_addr_t offs [9];
        timing_t   rstv [9];
        timing_t   prog [9];
        apb_data_t rd;
        logic      err;
        offs = '{REG_T_RC, REG_T_RAS, REG_T_RCD, REG_T_RP, REG_T_RTP, REG_T_WTP,
                 REG_T_BURST, REG_T_RFC, REG_ROW_OPEN};
        rstv = '{RST_T_RC, RST_T_RAS, RST_T_RCD, RST_T_RP, RST_T_RTP, RST_T_WTP,
                 RST_T_BURST, RST_T_RFC, RST_ROW_OPEN};
        prog = '{P_RC, P_RAS, P_RCD, P_RP, P_RTP, P_WTP, P_BURST, P_RFC, P_ROW_OPEN};
        for (int i = 0; i < 9; i++) begin
            apb_read(offs[i], rd, err);
            check_data(rd, {24'h0, rstv[i]}, $sformatf("reset value at %h", offs[i]));
            check_flag(err, 1'b0, "pslverr_o on mapped read");
        end
        for (int i = 0; i < 9; i++) begin
            apb_write(offs[i], {24'hA5C3E1, prog[i]}, err); // upper bits are dropped
            check_flag(err, 1'b0, "pslverr_o on mapped write");
        end
        for (int i = 0; i < 9; i++) begin
            apb_read(offs[i], rd, err);
            check_data(rd, {24'h0, prog[i]}, $sformatf("read back at %h", offs[i]));
        end
        apb_write(8'h24, 32'hFFFF_FFFF, err);
        check_flag(err, 1'b1, "pslverr_o on unmapped write");
        apb_read(8'h24, rd, err);
        check_flag(err, 1'b1, "pslverr_o on unmapped read");
        check_data(rd, 32'h0, "unmapped read data");
    endtask

    task automatic test_row_hit();
        int r;
        int g;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_wr_i    <= 1'b0;
        req_ra_i    <= ROW_A;
        req_ca_i    <= COL_A;
        wait_cmd(ACT, "activate", r);
        check_ra(ra_o, ROW_A, "ra_o with activate");
        check_ca(ca_o, '0, "ca_o with activate");
        grant_cmd(ACT, act_g);
        wait_cmd(RD, "read", r);
        check_gap(r - act_g - 1, P_RCD, "act grant to read");
        check_ra(ra_o, ROW_A, "ra_o with read");
        check_ca(ca_o, COL_A, "ca_o with read");
        grant_cmd(RD, g);
        req_wr_i <= 1'b1;                           // same row, write follows
        req_ca_i <= COL_B;
        wait_cmd(WR, "write on open row", r);
        check_gap(r - g - 1, P_BURST, "read grant to write");
        check_ra(ra_o, ROW_A, "ra_o with write");
        check_ca(ca_o, COL_B, "ca_o with write");
        grant_cmd(WR, wr_g);
        acc_g = wr_g;
        req_valid_i <= 1'b0;
    endtask

    task automatic test_row_miss();
        int r;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_wr_i    <= 1'b0;
        req_ra_i    <= ROW_B;
        req_ca_i    <= COL_A;
        wait_cmd(PRE, "precharge on row miss", r);
        check_gap(r - act_g - 1, P_RAS, "act grant to precharge");
        check_gap(r - wr_g - 1, P_WTP, "write grant to precharge");
        check_ra(ra_o, ROW_A, "ra_o with precharge");
        grant_cmd(PRE, pre_g);
        wait_cmd(ACT, "activate of new row", r);
        check_gap(r - pre_g - 1, P_RP, "pre grant to activate");
        check_ra(ra_o, ROW_B, "ra_o with new activate");
        grant_cmd(ACT, act_g);
        wait_cmd(RD, "read of new row", r);
        check_ca(ca_o, COL_A, "ca_o with read");
        grant_cmd(RD, acc_g);
        req_valid_i <= 1'b0;
    endtask

    task automatic test_refresh();
        int r;
        @(posedge clk);
        ref_req_i <= 1'b1;
        wait_cmd(PRE, "precharge before refresh", r);
        check_ra(ra_o, ROW_B, "ra_o with precharge");
        grant_cmd(PRE, pre_g);
        wait_cmd(REF, "refresh", r);
        check_gap(r - pre_g - 1, P_RP, "pre grant to refresh");
        check_ra(ra_o, '0, "ra_o with refresh");
        check_ca(ca_o, '0, "ca_o with refresh");
        grant_cmd(REF, ref_g);
        ref_req_i   <= 1'b0;
        req_valid_i <= 1'b1;
        req_wr_i    <= 1'b1;
        req_ra_i    <= ROW_C;
        req_ca_i    <= COL_B;
        wait_cmd(ACT, "activate after refresh", r);
        check_gap(r - ref_g - 1, P_RFC, "refresh grant to activate");
        check_gap(r - act_g - 1, P_RC, "act grant to next activate");
        check_ra(ra_o, ROW_C, "ra_o with activate");
        grant_cmd(ACT, act_g);
        wait_cmd(WR, "write after refresh", r);
        check_ca(ca_o, COL_B, "ca_o with write");
        grant_cmd(WR, acc_g);
        req_valid_i <= 1'b0;
    endtask

    task automatic test_idle_close();
        int r;
        wait_cmd(PRE, "idle close precharge", r);
        check_gap(r - acc_g - 1, P_ROW_OPEN, "last access to idle close");
        check_gap(r - act_g - 1, P_RAS, "act grant to idle close");
        check_ra(ra_o, ROW_C, "ra_o with idle close");
        grant_cmd(PRE, pre_g);
    endtask

    task automatic test_backpressure();
        int r;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_wr_i    <= 1'b0;
        req_ra_i    <= ROW_D;
        req_ca_i    <= COL_A;
        wait_cmd(ACT, "activate under back-pressure", r);
        check_ra(ra_o, ROW_D, "ra_o with activate");
        hold_cmd(ACT, 20);                          // no grant for 20 cycles
        grant_cmd(ACT, act_g);
        wait_cmd(RD, "read under back-pressure", r);
        check_ca(ca_o, COL_A, "ca_o with read");
        hold_cmd(RD, 20);
        grant_cmd(RD, acc_g);
        req_valid_i <= 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        paddr_i     = '0;
        psel_i      = 1'b0;
        penable_i   = 1'b0;
        pwrite_i    = 1'b0;
        pwdata_i    = '0;
        req_valid_i = 1'b0;
        req_wr_i    = 1'b0;
        req_ra_i    = '0;
        req_ca_i    = '0;
        ref_req_i   = 1'b0;
        gnt         = 5'b00000;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_regs();
        test_row_hit();
        test_row_miss();
        test_refresh();
        test_idle_close();
        test_backpressure();
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

/* bank_ctrl_assert.sv */
`timescale 1ns/1ps

module bank_ctrl_assert (
    input logic clk,
    input logic rst_n,
    input logic act_req_o,
    input logic rd_req_o,
    input logic wr_req_o,
    input logic pre_req_o,
    input logic ref_req_o,
    input logic act_gnt_i,
    input logic rd_gnt_i,
    input logic wr_gnt_i,
    input logic pre_gnt_i,
    input logic ref_gnt_i,
    input logic req_ready_o,
    input logic ref_gnt_o
);

    logic [4:0] reqs;
    logic [4:0] gnts;
    logic [4:0] pend_q;                             // requests left ungranted last cycle

    assign reqs = {ref_req_o, pre_req_o, wr_req_o, rd_req_o, act_req_o};
    assign gnts = {ref_gnt_i, pre_gnt_i, wr_gnt_i, rd_gnt_i, act_gnt_i};

    always @(posedge clk) begin
        if (!rst_n)
            pend_q <= '0;
        else
            pend_q <= reqs & ~gnts;
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(reqs))
        else $error("more than one command request at once");
    a_held: assert property (@(posedge clk) disable iff (!rst_n) (reqs & pend_q) == pend_q)
        else $error("command request dropped before its grant");
    // ready exactly when a pending read or write is granted
    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
                              req_ready_o == ((rd_req_o && rd_gnt_i) ||
                                              (wr_req_o && wr_gnt_i)))
        else $error("req_ready_o does not match the read or write grant");
    a_ref_gnt: assert property (@(posedge clk) disable iff (!rst_n)
                                ref_gnt_o == (ref_req_o && ref_gnt_i))
        else $error("ref_gnt_o does not match the granted refresh request");

endmodule

bind bank_ctrl_top bank_ctrl_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .act_req_o   (act_req_o),
    .rd_req_o    (rd_req_o),
    .wr_req_o    (wr_req_o),
    .pre_req_o   (pre_req_o),
    .ref_req_o   (ref_req_o),
    .act_gnt_i   (act_gnt_i),
    .rd_gnt_i    (rd_gnt_i),
    .wr_gnt_i    (wr_gnt_i),
    .pre_gnt_i   (pre_gnt_i),
    .ref_gnt_i   (ref_gnt_i),
    .req_ready_o (req_ready_o),
    .ref_gnt_o   (ref_gnt_o)
);

/* bank_ctrl_top.sv */
`timescale 1ns/1ps

module bank_ctrl_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // apb
    input  bank_ctrl_pkg::apb_addr_t paddr_i,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  bank_ctrl_pkg::apb_data_t pwdata_i,
    output bank_ctrl_pkg::apb_data_t prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o,
    // request port
    input  logic                     req_valid_i,
    input  logic                     req_wr_i,
    input  bank_ctrl_pkg::dram_ra_t  req_ra_i,
    input  bank_ctrl_pkg::dram_ca_t  req_ca_i,
    output logic                     req_ready_o,
    // command requests to the scheduler
    output logic                     act_req_o,
    output logic                     rd_req_o,
    output logic                     wr_req_o,
    output logic                     pre_req_o,
    output logic                     ref_req_o,
    output bank_ctrl_pkg::dram_ra_t  ra_o,
    output bank_ctrl_pkg::dram_ca_t  ca_o,
    input  logic                     act_gnt_i,
    input  logic                     rd_gnt_i,
    input  logic                     wr_gnt_i,
    input  logic                     pre_gnt_i,
    input  logic                     ref_gnt_i,
    // refresh port
    input  logic                     ref_req_i,
    output logic                     ref_gnt_o
);

    timing_cfg_if cfg_if   ();                      // register values to timers
    bank_timer_if flags_if ();                      // met flags to fsm

    bank_timing_regs u_regs (
        .clk, .rst_n, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
        .prdata_o, .pready_o, .pslverr_o,
        .cfg   (cfg_if.regs)
    );

    bank_timers u_timers (
        .clk, .rst_n, .act_gnt_i, .rd_gnt_i, .wr_gnt_i, .pre_gnt_i, .ref_gnt_i,
        .cfg   (cfg_if.timers),
        .flags (flags_if.timers)
    );

    bank_fsm u_fsm (
        .clk, .rst_n,
        .flags (flags_if.fsm),
        .req_valid_i, .req_wr_i, .req_ra_i, .req_ca_i, .req_ready_o,
        .act_req_o, .rd_req_o, .wr_req_o, .pre_req_o, .ref_req_o,
        .act_gnt_i, .rd_gnt_i, .wr_gnt_i, .pre_gnt_i, .ref_gnt_i,
        .ra_o, .ca_o, .ref_req_i, .ref_gnt_o
    );

endmodule

/* bank_fsm.sv */
`timescale 1ns/1ps

module bank_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    bank_timer_if.fsm               flags,
    input  logic                    req_valid_i,
    input  logic                    req_wr_i,
    input  bank_ctrl_pkg::dram_ra_t req_ra_i,
    input  bank_ctrl_pkg::dram_ca_t req_ca_i,
    output logic                    req_ready_o,
    output logic                    act_req_o,
    output logic                    rd_req_o,
    output logic                    wr_req_o,
    output logic                    pre_req_o,
    output logic                    ref_req_o,
    input  logic                    act_gnt_i,
    input  logic                    rd_gnt_i,
    input  logic                    wr_gnt_i,
    input  logic                    pre_gnt_i,
    input  logic                    ref_gnt_i,
    output bank_ctrl_pkg::dram_ra_t ra_o,
    output bank_ctrl_pkg::dram_ca_t ca_o,
    input  logic                    ref_req_i,
    output logic                    ref_gnt_o
);
    import bank_ctrl_pkg::*;

    bank_state_e state, state_n;
    dram_ra_t    open_ra;                           // currently open row
    logic        act_pend;                          // act raised, not yet granted
    logic        pre_pend;                          // pre raised, not yet granted
    logic        row_hit;
    logic        pre_ok;                            // all pre timings met

    assign row_hit = (req_ra_i == open_ra);
    assign pre_ok  = flags.ras_met & flags.rtp_met & flags.wtp_met;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            act_pend <= 1'b0;
            pre_pend <= 1'b0;
        end else begin
            state    <= state_n;
            act_pend <= act_req_o & ~act_gnt_i;     // keep act stable under back-pressure
            pre_pend <= pre_req_o & ~pre_gnt_i;     // same for pre
        end
    end

    always_ff @(posedge clk) begin
        if (act_req_o && act_gnt_i)
            open_ra <= req_ra_i;                    // row latched on activate
    end

    always_comb begin
        state_n     = state;
        req_ready_o = 1'b0;
        act_req_o   = 1'b0;
        rd_req_o    = 1'b0;
        wr_req_o    = 1'b0;
        pre_req_o   = 1'b0;
        ref_req_o   = 1'b0;
        ref_gnt_o   = 1'b0;
        ra_o        = '0;
        ca_o        = '0;
        case (state)
            S_IDLE: begin
                if (!act_pend && flags.rc_met && ref_req_i) begin
                    ref_req_o = 1'b1;               // refresh wins over access
                    ref_gnt_o = ref_gnt_i;
                    if (ref_gnt_i)
                        state_n = S_REFRESHING;
                end else if (act_pend || (flags.rc_met && req_valid_i)) begin
                    act_req_o = 1'b1;
                    ra_o      = req_ra_i;
                    if (act_gnt_i)
                        state_n = S_ACTIVATING;
                end
            end
            S_ACTIVATING: begin
                if (flags.rcd_met)
                    state_n = S_BANK_ACTIVE;
            end
            S_BANK_ACTIVE: begin
                if (!pre_pend && req_valid_i && row_hit && flags.burst_met) begin
                    rd_req_o    = ~req_wr_i;
                    wr_req_o    = req_wr_i;
                    ra_o        = open_ra;
                    ca_o        = req_ca_i;
                    req_ready_o = req_wr_i ? wr_gnt_i : rd_gnt_i; // accept on grant
                end else if (pre_pend || (pre_ok && ((req_valid_i && !row_hit) ||
                             ref_req_i || (flags.row_open_met && !req_valid_i)))) begin
                    pre_req_o = 1'b1;               // miss, refresh or idle close
                    ra_o      = open_ra;
                    if (pre_gnt_i)
                        state_n = S_PRECHARGING;
                end
            end
            S_PRECHARGING: begin
                if (flags.rp_met)
                    state_n = S_IDLE;
            end
            S_REFRESHING: begin
                if (flags.rfc_met)
                    state_n = S_IDLE;
            end
            default: state_n = S_IDLE;              // unused encodings
        endcase
    end

endmodule

/* bank_timers.sv */
`timescale 1ns/1ps

module bank_timers (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         act_gnt_i,
    input  logic         rd_gnt_i,
    input  logic         wr_gnt_i,
    input  logic         pre_gnt_i,
    input  logic         ref_gnt_i,
    timing_cfg_if.timers cfg,
    bank_timer_if.timers flags
);
    import bank_ctrl_pkg::*;

    logic [8:0] load;                               // per-counter load strobe
    timing_t    ld_val [9];                         // per-counter load value
    timing_t    cnt    [9];                         // remaining blocked cycles
    logic [8:0] met;                                // counter reached zero

    assign load[0] = act_gnt_i;
    assign load[1] = act_gnt_i;
    assign load[2] = act_gnt_i;
    assign load[3] = pre_gnt_i;
    assign load[4] = rd_gnt_i;
    assign load[5] = wr_gnt_i;
    assign load[6] = rd_gnt_i | wr_gnt_i;
    assign load[7] = ref_gnt_i;
    assign load[8] = act_gnt_i | rd_gnt_i | wr_gnt_i;

    assign ld_val[0] = cfg.t_rc;
    assign ld_val[1] = cfg.t_ras;
    assign ld_val[2] = cfg.t_rcd;
    assign ld_val[3] = cfg.t_rp;
    assign ld_val[4] = cfg.t_rtp;
    assign ld_val[5] = cfg.t_wtp;
    assign ld_val[6] = cfg.t_burst;
    assign ld_val[7] = cfg.t_rfc;
    assign ld_val[8] = cfg.row_open;                // restarted by any row access

    for (genvar i = 0; i < 9; i++) begin : g_cnt
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                cnt[i] <= '0;                       // nothing blocked after reset
            end else if (load[i]) begin
                cnt[i] <= ld_val[i];                // blocks for ld_val cycles
            end else if (cnt[i] != '0) begin
                cnt[i] <= cnt[i] - 8'd1;            // saturate at zero
            end
        end
        assign met[i] = (cnt[i] == '0);
    end

    assign flags.rc_met       = met[0];
    assign flags.ras_met      = met[1];
    assign flags.rcd_met      = met[2];
    assign flags.rp_met       = met[3];
    assign flags.rtp_met      = met[4];
    assign flags.wtp_met      = met[5];
    assign flags.burst_met    = met[6];
    assign flags.rfc_met      = met[7];
    assign flags.row_open_met = met[8];

endmodule

/* bank_timing_regs.sv */
`timescale 1ns/1ps

module bank_timing_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  bank_ctrl_pkg::apb_addr_t paddr_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  bank_ctrl_pkg::apb_data_t pwdata_i,
    output bank_ctrl_pkg::apb_data_t prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    timing_cfg_if.regs              cfg
);
    import bank_ctrl_pkg::*;

    timing_t    regs [9];                           // 0 rc .. 8 row_open
    logic [3:0] sel_idx;                            // decoded register index
    logic       hit;                                // offset is mapped
    logic       access;                             // apb access phase

    assign access = psel_i & penable_i;

    always_comb begin
        sel_idx = 4'd0;
        hit     = 1'b1;
        case (paddr_i)
            REG_T_RC:     sel_idx = 4'd0;
            REG_T_RAS:    sel_idx = 4'd1;
            REG_T_RCD:    sel_idx = 4'd2;
            REG_T_RP:     sel_idx = 4'd3;
            REG_T_RTP:    sel_idx = 4'd4;
            REG_T_WTP:    sel_idx = 4'd5;
            REG_T_BURST:  sel_idx = 4'd6;
            REG_T_RFC:    sel_idx = 4'd7;
            REG_ROW_OPEN: sel_idx = 4'd8;
            default:      hit     = 1'b0;       // hole in the map
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs[0] <= RST_T_RC;
            regs[1] <= RST_T_RAS;
            regs[2] <= RST_T_RCD;
            regs[3] <= RST_T_RP;
            regs[4] <= RST_T_RTP;
            regs[5] <= RST_T_WTP;
            regs[6] <= RST_T_BURST;
            regs[7] <= RST_T_RFC;
            regs[8] <= RST_ROW_OPEN;
        end else if (access && pwrite_i && hit) begin
            regs[sel_idx] <= pwdata_i[7:0];         // only low byte is stored
        end
    end

    // read mux, zero outside a mapped read
    assign prdata_o  = (access && !pwrite_i && hit) ? {24'h0, regs[sel_idx]} : '0;
    assign pready_o  = 1'b1;                        // no wait states
    assign pslverr_o = access & ~hit;               // unmapped offset

    assign cfg.t_rc     = regs[0];
    assign cfg.t_ras    = regs[1];
    assign cfg.t_rcd    = regs[2];
    assign cfg.t_rp     = regs[3];
    assign cfg.t_rtp    = regs[4];
    assign cfg.t_wtp    = regs[5];
    assign cfg.t_burst  = regs[6];
    assign cfg.t_rfc    = regs[7];
    assign cfg.row_open = regs[8];

endmodule

/* bank_timer_if.sv */
`timescale 1ns/1ps

interface bank_timer_if;

    logic rc_met;                                   // act allowed after last act
    logic ras_met;                                  // row open long enough
    logic rcd_met;                                  // rd/wr allowed after act
    logic rp_met;                                   // precharge done
    logic rtp_met;                                  // pre allowed after rd
    logic wtp_met;                                  // pre allowed after wr
    logic burst_met;                                // next burst allowed
    logic rfc_met;                                  // refresh done
    logic row_open_met;                             // row idle long enough

    modport timers (
        output rc_met, ras_met, rcd_met, rp_met, rtp_met, wtp_met,
               burst_met, rfc_met, row_open_met
    );

    modport fsm (
        input  rc_met, ras_met, rcd_met, rp_met, rtp_met, wtp_met,
               burst_met, rfc_met, row_open_met
    );

endinterface

/* timing_cfg_if.sv */
`timescale 1ns/1ps

interface timing_cfg_if;
    import bank_ctrl_pkg::*;

    timing_t t_rc;                                  // act to act
    timing_t t_ras;                                 // act to pre
    timing_t t_rcd;                                 // act to rd/wr
    timing_t t_rp;                                  // pre to act
    timing_t t_rtp;                                 // rd to pre
    timing_t t_wtp;                                 // wr to pre
    timing_t t_burst;                               // rd/wr spacing
    timing_t t_rfc;                                 // ref to act
    timing_t row_open;                              // idle row close limit

    modport regs (
        output t_rc, t_ras, t_rcd, t_rp, t_rtp, t_wtp, t_burst, t_rfc, row_open
    );

    modport timers (
        input  t_rc, t_ras, t_rcd, t_rp, t_rtp, t_wtp, t_burst, t_rfc, row_open
    );

endinterface

/* bank_ctrl_pkg.sv */
package bank_ctrl_pkg;

    typedef logic [13:0] dram_ra_t;                 // row address
    typedef logic [9:0]  dram_ca_t;                 // column address
    typedef logic [7:0]  timing_t;                  // one timing value, in clocks
    typedef logic [7:0]  apb_addr_t;                // apb byte address
    typedef logic [31:0] apb_data_t;                // apb data word

    typedef enum logic [2:0] {
        S_IDLE        = 3'd0,                       // bank closed
        S_ACTIVATING  = 3'd1,                       // waiting out trcd
        S_BANK_ACTIVE = 3'd2,                       // row open, rd/wr allowed
        S_PRECHARGING = 3'd3,                       // waiting out trp
        S_REFRESHING  = 3'd4                        // waiting out trfc
    } bank_state_e;

    // register map
    localparam apb_addr_t REG_T_RC     = 8'h00;
    localparam apb_addr_t REG_T_RAS    = 8'h04;
    localparam apb_addr_t REG_T_RCD    = 8'h08;
    localparam apb_addr_t REG_T_RP     = 8'h0C;
    localparam apb_addr_t REG_T_RTP    = 8'h10;
    localparam apb_addr_t REG_T_WTP    = 8'h14;
    localparam apb_addr_t REG_T_BURST  = 8'h18;
    localparam apb_addr_t REG_T_RFC    = 8'h1C;
    localparam apb_addr_t REG_ROW_OPEN = 8'h20;

    // power-up timing, in clocks
    localparam timing_t RST_T_RC     = 8'd20;
    localparam timing_t RST_T_RAS    = 8'd14;
    localparam timing_t RST_T_RCD    = 8'd5;
    localparam timing_t RST_T_RP     = 8'd5;
    localparam timing_t RST_T_RTP    = 8'd3;
    localparam timing_t RST_T_WTP    = 8'd8;
    localparam timing_t RST_T_BURST  = 8'd4;
    localparam timing_t RST_T_RFC    = 8'd30;
    localparam timing_t RST_ROW_OPEN = 8'd40;

endpackage
